// ==== logic/checkerboard_gen.sv ====
`timescale 1ns/100ps
// Stage 1 checkerboard generator with a horizontally scrolling offset
module checkerboard_gen (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        next_frame,
    input  logic                        restart,
    input  vga_pattern_pkg::pixel_pos_t pos,
    input  vga_pattern_pkg::step_t      step_size,
    output vga_pattern_pkg::rgb_t       rgb
);
    import vga_pattern_pkg::*;

    logic [5:0] offset;  // Scroll position within one 64-pixel period
    logic [5:0] col;
    logic       white;

    // 32x32 squares, the columns slide left as the offset grows
    assign col   = pos.x[5:0] + offset;
    assign white = col[5] ^ pos.y[5];

    // Scroll update, restart has priority over a frame step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            offset <= '0;
        end else if (restart) begin
            offset <= '0;
        end else if (next_frame) begin
            offset <= offset + 6'(step_size);  // Wraps within the period
        end
    end

    // Colour is registered one cycle after pos
    always_ff @(posedge clk) begin
        if (white) begin
            rgb <= RGB_WHITE;
        end else begin
            rgb <= RGB_BLACK;
        end
    end

endmodule

// ==== logic/gradient_gen.sv ====
`timescale 1ns/100ps
// Stage 1 diagonal gradient generator with a moving phase
module gradient_gen (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        next_frame,
    input  logic                        restart,
    input  vga_pattern_pkg::pixel_pos_t pos,
    input  vga_pattern_pkg::step_t      step_size,
    output vga_pattern_pkg::rgb_t       rgb
);
    logic [5:0] phase;
    logic [5:0] level;  // Position along the diagonal, modulo 64

    // Lines of equal x+y run from top right to bottom left
    assign level = pos.x[5:0] + pos.y[5:0] + phase;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= '0;
        end else if (restart) begin
            phase <= '0;
        end else if (next_frame) begin
            phase <= phase + 6'(step_size);
        end
    end

    // Upper bits drive red, lower bits blue, so the colour cycles faster in blue
    always_ff @(posedge clk) begin
        rgb <= '{r: level[5:4], g: level[3:2], b: level[1:0]};
    end

endmodule

// ==== logic/pattern_selector.sv ====
`timescale 1ns/100ps
// Stage 2 pattern selector: frame counting, pattern sequencing, generator strobes, output register
module pattern_selector #(
    parameter int FRAMES_PER_PATTERN = 300
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        paused,
    input  vga_pattern_pkg::pixel_pos_t pos,
    input  vga_pattern_pkg::rgb_t       checker_rgb,
    input  vga_pattern_pkg::rgb_t       gradient_rgb,
    input  vga_pattern_pkg::rgb_t       radial_rgb,
    output logic                        checker_next,
    output logic                        gradient_next,
    output logic                        radial_next,
    output logic                        restart,
    output logic                        hsync,
    output logic                        vsync,
    output vga_pattern_pkg::rgb_t       rgb
);
    import vga_pattern_pkg::*;

    localparam int FW = $clog2(FRAMES_PER_PATTERN + 1);

    pattern_t    pattern;
    logic [FW-1:0] frame_cnt;
    logic        vsync_q;      // pos.vsync of the previous cycle
    logic        frame_edge;
    logic        anim_step;
    logic        last_frame;
    logic        active_d;     // Syncs and active delayed to match the generators
    logic        hsync_d;
    logic        vsync_d;
    rgb_t        sel_rgb;

    // End of the vsync pulse marks a new frame
    assign frame_edge = pos.vsync && !vsync_q;
    assign anim_step  = frame_edge && !paused;
    assign last_frame = (frame_cnt == FW'(FRAMES_PER_PATTERN - 1));

    // Only the generator on screen advances
    assign checker_next  = anim_step && (pattern == PAT_CHECKER);
    assign gradient_next = anim_step && (pattern == PAT_GRADIENT);
    assign radial_next   = anim_step && (pattern == PAT_RADIAL);

    // Frame counting runs while paused too
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vsync_q   <= 1'b1;
            frame_cnt <= '0;
            pattern   <= PAT_CHECKER;
            restart   <= 1'b0;
        end else begin
            vsync_q <= pos.vsync;
            restart <= 1'b0;
            if (frame_edge) begin
                if (last_frame) begin
                    frame_cnt <= '0;
                    if (pattern == pattern_t'(N_PATTERNS - 1)) begin
                        pattern <= PAT_CHECKER;
                        restart <= 1'b1;  // All phases back to zero
                    end else begin
                        pattern <= pattern_t'(pattern + 2'd1);
                    end
                end else begin
                    frame_cnt <= frame_cnt + FW'(1);
                end
            end
        end
    end

    always_comb begin
        case (pattern)
            PAT_CHECKER:  sel_rgb = checker_rgb;
            PAT_GRADIENT: sel_rgb = gradient_rgb;
            PAT_RADIAL:   sel_rgb = radial_rgb;
            default:      sel_rgb = RGB_BLACK;
        endcase
    end

    // Two register stages, the first lines up with the generator outputs
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_d <= 1'b0;
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
            hsync    <= 1'b1;
            vsync    <= 1'b1;
            rgb      <= RGB_BLACK;
        end else begin
            active_d <= pos.active;
            hsync_d  <= pos.hsync;
            vsync_d  <= pos.vsync;
            hsync    <= hsync_d;
            vsync    <= vsync_d;
            rgb      <= active_d ? sel_rgb : RGB_BLACK;  // Blank outside the visible area
        end
    end

    a_pattern_legal: assert property (
        @(posedge clk) disable iff (rst)
        pattern inside {PAT_CHECKER, PAT_GRADIENT, PAT_RADIAL}
    );

endmodule

// ==== logic/radial_arm_gen.sv ====
`timescale 1ns/100ps
// Stage 1 radial arm generator: octant wheel around the screen centre with rotation
module radial_arm_gen #(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 480
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        next_frame,
    input  logic                        restart,
    input  vga_pattern_pkg::pixel_pos_t pos,
    input  vga_pattern_pkg::step_t      step_size,
    output vga_pattern_pkg::rgb_t       rgb
);
    import vga_pattern_pkg::*;

    // Centre of the visible area
    localparam logic signed [10:0] CX = 11'(H_ACTIVE / 2);
    localparam logic signed [10:0] CY = 11'(V_ACTIVE / 2);

    logic [2:0]         rotation;
    logic signed [10:0] dx;
    logic signed [10:0] dy;
    logic [10:0]        adx;
    logic [10:0]        ady;
    logic [2:0]         octant;
    logic [2:0]         pal_idx;

    assign dx = signed'({1'b0, pos.x}) - CX;
    assign dy = signed'({1'b0, pos.y}) - CY;

    // Magnitudes, used to split each quadrant along its diagonal
    assign adx = dx[10] ? 11'(-dx) : 11'(dx);
    assign ady = dy[10] ? 11'(-dy) : 11'(dy);

    assign octant  = {dx[10], dy[10], (adx < ady)};
    assign pal_idx = octant + rotation;  // Modulo 8 by width

    // Wheel rotation, one palette slot per step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rotation <= '0;
        end else if (restart) begin
            rotation <= '0;
        end else if (next_frame) begin
            rotation <= rotation + step_size;
        end
    end

    always_ff @(posedge clk) begin
        rgb <= RADIAL_PALETTE[pal_idx];
    end

    // The selector sends restart only after the last radial frame step
    a_no_step_on_restart: assert property (
        @(posedge clk) disable iff (rst)
        !(next_frame && restart)
    );

endmodule

// ==== logic/vga_pattern_pkg.sv ====
// Shared types and constants: pixel position, colour, pattern codes, step size, radial palette
package vga_pattern_pkg;

    // Number of patterns in the display sequence
    localparam int N_PATTERNS = 3;

    // Pixel position and sync levels from the timing generator
    // Both syncs are active low
    typedef struct packed {
        logic [9:0] x;       // Horizontal counter, runs through blanking
        logic [9:0] y;       // Vertical counter, runs through blanking
        logic       active;  // Inside the visible area
        logic       hsync;
        logic       vsync;
    } pixel_pos_t;

    // 6-bit colour, 2 bits per channel
    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } rgb_t;

    // Pattern codes in display order
    typedef enum logic [1:0] {
        PAT_CHECKER  = 2'd0,
        PAT_GRADIENT = 2'd1,
        PAT_RADIAL   = 2'd2
    } pattern_t;

    // Animation step added to a phase per frame
    typedef logic [2:0] step_t;

    // One colour per octant of the wheel, going round the centre
    localparam rgb_t RADIAL_PALETTE [0:7] = '{
        '{r: 2'b11, g: 2'b00, b: 2'b00},  // Red
        '{r: 2'b11, g: 2'b10, b: 2'b00},  // Orange
        '{r: 2'b11, g: 2'b11, b: 2'b00},  // Yellow
        '{r: 2'b00, g: 2'b11, b: 2'b00},  // Green
        '{r: 2'b00, g: 2'b11, b: 2'b11},  // Cyan
        '{r: 2'b00, g: 2'b00, b: 2'b11},  // Blue
        '{r: 2'b10, g: 2'b00, b: 2'b11},  // Violet
        '{r: 2'b11, g: 2'b00, b: 2'b11}   // Magenta
    };

    // The wheel needs eight distinct arms
    localparam int N_OCTANTS = 8;

    // Colour constants used by the generators and the selector
    localparam rgb_t RGB_BLACK = '{r: 2'b00, g: 2'b00, b: 2'b00};
    localparam rgb_t RGB_WHITE = '{r: 2'b11, g: 2'b11, b: 2'b11};

endpackage

// ==== logic/vga_pattern_top.sv ====
`timescale 1ns/100ps
// Top level: timing generator, three pattern generators and the pattern selector
module vga_pattern_top #(
    parameter int H_ACTIVE           = 640,
    parameter int H_FRONT            = 16,
    parameter int H_SYNC             = 96,
    parameter int H_BACK             = 48,
    parameter int V_ACTIVE           = 480,
    parameter int V_FRONT            = 10,
    parameter int V_SYNC             = 2,
    parameter int V_BACK             = 33,
    parameter int FRAMES_PER_PATTERN = 300
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   paused,
    input  vga_pattern_pkg::step_t step_size,
    output logic                   hsync,
    output logic                   vsync,
    output vga_pattern_pkg::rgb_t  rgb
);
    import vga_pattern_pkg::*;

    pixel_pos_t pos;
    rgb_t       checker_rgb;
    rgb_t       gradient_rgb;
    rgb_t       radial_rgb;
    logic       checker_next;
    logic       gradient_next;
    logic       radial_next;
    logic       restart;       // Shared by all generators

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timing (
        .clk(clk), .rst(rst), .pos(pos)
    );

    checkerboard_gen u_checker (
        .clk(clk), .rst(rst), .next_frame(checker_next), .restart(restart),
        .pos(pos), .step_size(step_size), .rgb(checker_rgb)
    );

    gradient_gen u_gradient (
        .clk(clk), .rst(rst), .next_frame(gradient_next), .restart(restart),
        .pos(pos), .step_size(step_size), .rgb(gradient_rgb)
    );

    radial_arm_gen #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_radial (
        .clk(clk), .rst(rst), .next_frame(radial_next), .restart(restart),
        .pos(pos), .step_size(step_size), .rgb(radial_rgb)
    );

    pattern_selector #(.FRAMES_PER_PATTERN(FRAMES_PER_PATTERN)) u_selector (
        .clk(clk), .rst(rst), .paused(paused), .pos(pos),
        .checker_rgb(checker_rgb), .gradient_rgb(gradient_rgb), .radial_rgb(radial_rgb),
        .checker_next(checker_next), .gradient_next(gradient_next),
        .radial_next(radial_next), .restart(restart),
        .hsync(hsync), .vsync(vsync), .rgb(rgb)
    );

endmodule

// ==== logic/vga_timing.sv ====
`timescale 1ns/100ps
// Stage 0 timing generator: horizontal and vertical counters, sync and active decode
module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                        clk,
    input  logic                        rst,
    output vga_pattern_pkg::pixel_pos_t pos
);
    import vga_pattern_pkg::*;

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    logic [9:0] x_nxt;
    logic [9:0] y_nxt;
    pixel_pos_t pos_nxt;

    // Horizontal first, the vertical counter steps at the end of each line
    always_comb begin
        x_nxt = pos.x + 10'd1;
        y_nxt = pos.y;
        if (pos.x == 10'(H_TOTAL - 1)) begin
            x_nxt = '0;
            if (pos.y == 10'(V_TOTAL - 1)) begin
                y_nxt = '0;
            end else begin
                y_nxt = pos.y + 10'd1;
            end
        end
    end

    // Regions decoded from the next count so that pos stays aligned
    always_comb begin
        pos_nxt.x      = x_nxt;
        pos_nxt.y      = y_nxt;
        pos_nxt.active = (x_nxt < 10'(H_ACTIVE)) && (y_nxt < 10'(V_ACTIVE));
        pos_nxt.hsync  = !((x_nxt >= 10'(H_SYNC_START)) && (x_nxt < 10'(H_SYNC_END)));
        pos_nxt.vsync  = !((y_nxt >= 10'(V_SYNC_START)) && (y_nxt < 10'(V_SYNC_END)));
    end

    // The registered position doubles as the counter state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos <= '{x: '0, y: '0, active: 1'b1, hsync: 1'b1, vsync: 1'b1};
        end else begin
            pos <= pos_nxt;
        end
    end

    // Generators rely on active never flagging a blanking pixel
    a_active_in_area: assert property (
        @(posedge clk) disable iff (rst)
        pos.active |-> ((pos.x < 10'(H_ACTIVE)) && (pos.y < 10'(V_ACTIVE)))
    );

endmodule

// ==== verif/vga_pattern_checks.svh ====
// Reference pattern model, position tracking from the sync edges, and compare tasks
`ifndef VGA_PATTERN_CHECKS_SVH
`define VGA_PATTERN_CHECKS_SVH

int   obs_x;
int   obs_y;
bit   locked = 1'b0;                    // Position known after the first vsync rise
int   frame_num = 0;                    // Frames since reset
int   cycle_cnt = 0;
int   phase [N_PATTERNS] = '{0, 0, 0};  // Checker offset, gradient phase, radial rotation
logic hsync_q = 1'b1;
logic vsync_q = 1'b1;
bit   hsync_rose;
bit   hsync_fell;
bit   vsync_rose;
bit   vsync_fell;

function automatic pattern_t pattern_of(int frame);
    return pattern_t'((frame / FRAMES_PER_PATTERN) % N_PATTERNS);
endfunction

// Colour of one pixel for a pattern and its phase, black in blanking
function automatic rgb_t expected_colour(int x, int y, pattern_t pat, int ph);
    int       dx;
    int       dy;
    bit [2:0] oct;
    rgb_t     c;
    dx  = x - H_ACTIVE / 2;
    dy  = y - V_ACTIVE / 2;
    oct = {dx < 0, dy < 0, (dx < 0 ? -dx : dx) < (dy < 0 ? -dy : dy)};
    c   = rgb_t'(6'h00);
    if (x < H_ACTIVE && y < V_ACTIVE) begin
        case (pat)
            PAT_CHECKER:  c = ((((x + ph) / 32) % 2) != ((y / 32) % 2)) ? rgb_t'(6'h3f) : c;
            PAT_GRADIENT: c = rgb_t'(6'((x + y + ph) % 64));
            default:      c = RADIAL_PALETTE[(oct + ph) % 8];
        endcase
    end
    return c;
endfunction

// Frame edge: the pattern on screen steps unless paused, a wrap clears every phase
task automatic advance_model();
    pattern_t cur;
    cur = pattern_of(frame_num);
    if (!paused) begin
        phase[cur] = (phase[cur] + step_size) % ((cur == PAT_RADIAL) ? 8 : 64);
    end
    frame_num++;
    if (cur == PAT_RADIAL && pattern_of(frame_num) == PAT_CHECKER) begin
        phase = '{0, 0, 0};
    end
endtask

// One output sample at the falling clock edge
task automatic observe();
    @(negedge clk);
    cycle_cnt++;
    hsync_rose = hsync && !hsync_q;
    hsync_fell = !hsync && hsync_q;
    vsync_rose = vsync && !vsync_q;
    vsync_fell = !vsync && vsync_q;
    hsync_q    = hsync;
    vsync_q    = vsync;
    if (locked) begin
        obs_x = (obs_x + 1) % H_TOTAL;
        if (obs_x == 0) begin
            obs_y = (obs_y + 1) % V_TOTAL;
        end
    end
    // A vsync rise is the first pixel of the vertical back porch
    if (vsync_rose && !locked) begin
        locked = 1'b1;
        obs_x  = 0;
        obs_y  = V_SYNC_START + V_SYNC;
    end
    if (vsync_rose) begin
        advance_model();
    end
endtask

task automatic check_rgb(string name, rgb_t exp, rgb_t act);
    if (act !== exp) begin
        rgb_errors++;
        $display("Fail %s: expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_sync(string name, logic exp, logic act);
    if (act !== exp) begin
        sync_errors++;
        $display("Fail %s: expected %b actual %b", name, exp, act);
    end
endtask

task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
        count_errors++;
        $display("Fail %s: expected %0d actual %0d", name, exp, act);
    end
endtask

`endif

// ==== verif/vga_pattern_tb.sv ====
`timescale 1ns/100ps
// VGA pattern testbench: clock, reset, watchdog, directed tests and result line
module vga_pattern_tb;
    import vga_pattern_pkg::*;

    localparam int H_ACTIVE           = 24;
    localparam int H_FRONT            = 2;
    localparam int H_SYNC             = 3;
    localparam int H_BACK             = 2;
    localparam int V_ACTIVE           = 12;
    localparam int V_FRONT            = 1;
    localparam int V_SYNC             = 2;
    localparam int V_BACK             = 2;
    localparam int FRAMES_PER_PATTERN = 3;
    localparam int H_TOTAL            = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL            = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START       = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START       = V_ACTIVE + V_FRONT;
    localparam int FRAME_CYCLES       = H_TOTAL * V_TOTAL;
    localparam int N_PIXELS           = H_ACTIVE * V_ACTIVE;
    localparam int CLK_PERIOD         = 20;
    localparam int RESET_CYCLES       = 10;
    localparam int TEST_FRAMES        = 19;  // 2 sync, 1 blanking, 3 animation, 5 pause, 8 wrap

    logic  clk = 1'b0;
    logic  rst = 1'b1;
    logic  paused = 1'b0;
    step_t step_size = '0;
    logic  hsync;
    logic  vsync;
    rgb_t  rgb;

    int    rgb_errors = 0;
    int    sync_errors = 0;
    int    count_errors = 0;
    int    active_count;
    int    active_lines;
    rgb_t  image [N_PIXELS];       // Visible pixels of the last frame
    rgb_t  prev_image [N_PIXELS];

    `include "vga_pattern_checks.svh"

    vga_pattern_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .FRAMES_PER_PATTERN(FRAMES_PER_PATTERN)
    ) i_dut (
        .clk(clk), .rst(rst), .paused(paused), .step_size(step_size),
        .hsync(hsync), .vsync(vsync), .rgb(rgb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic wait_for_sync_edge(bit vertical, bit rising);
        do begin
            observe();
        end while (!(vertical ? (rising ? vsync_rose : vsync_fell)
                              : (rising ? hsync_rose : hsync_fell)));
    endtask

    // Syncs and colour of the current sample against the model
    task automatic check_pixel(string name);
        pattern_t pat;
        string    where;
        pat   = pattern_of(frame_num);
        where = $sformatf("%s x%0d y%0d frame %0d", name, obs_x, obs_y, frame_num);
        check_sync({where, " hsync"},
                   !(obs_x >= H_SYNC_START && obs_x < H_SYNC_START + H_SYNC), hsync);
        check_sync({where, " vsync"},
                   !(obs_y >= V_SYNC_START && obs_y < V_SYNC_START + V_SYNC), vsync);
        check_rgb(where, expected_colour(obs_x, obs_y, pat, phase[pat]), rgb);
        if (obs_x < H_ACTIVE && obs_y < V_ACTIVE) begin
            image[obs_y * H_ACTIVE + obs_x] = rgb;
            active_count++;
            active_lines += (obs_x == 0);
        end
    endtask

    // Inputs are held from one vsync fall to the next, well clear of the frame edge
    task automatic run_frame(string name, logic pause_level, step_t step);
        @(posedge clk);
        paused    <= pause_level;
        step_size <= step;
        active_count = 0;
        active_lines = 0;
        do begin
            observe();
            if (locked) begin
                check_pixel(name);
            end
        end while (!vsync_fell);
    endtask

    task automatic test_sync_timing();
        int t0;
        wait_for_sync_edge(1'b0, 1'b0);
        t0 = cycle_cnt;
        wait_for_sync_edge(1'b0, 1'b1);
        check_count("sync_timing hsync width", H_SYNC, cycle_cnt - t0);
        wait_for_sync_edge(1'b0, 1'b0);
        check_count("sync_timing hsync period", H_TOTAL, cycle_cnt - t0);
        wait_for_sync_edge(1'b1, 1'b0);
        t0 = cycle_cnt;
        wait_for_sync_edge(1'b1, 1'b1);
        check_count("sync_timing vsync width in cycles", V_SYNC * H_TOTAL, cycle_cnt - t0);
        wait_for_sync_edge(1'b1, 1'b0);
        check_count("sync_timing vsync period in cycles", V_TOTAL * H_TOTAL, cycle_cnt - t0);
    endtask

    task automatic test_blanking();
        run_frame("blanking", 1'b0, step_t'($urandom % 8));
        check_count("blanking active pixels", N_PIXELS, active_count);
        check_count("blanking active lines", V_ACTIVE, active_lines);
    endtask

    task automatic test_animation();
        repeat (3) begin
            run_frame("animation", 1'b0, step_t'($urandom % 8));  // Gradient period
        end
    endtask

    // Radial frames then the wrap to the checkerboard, all paused
    task automatic test_pause();
        pattern_t last_pat;
        int       diff;
        int       f;
        int       i;
        for (f = 0; f < 5; f++) begin
            // Nonzero step, so a frame that steps despite the pause shows up
            run_frame("pause", 1'b1, step_t'(1 + $urandom % 7));
            diff = 0;
            for (i = 0; i < N_PIXELS; i++) begin
                if (f > 0 && pattern_of(frame_num) == last_pat) begin
                    check_rgb($sformatf("pause repeat pixel %0d", i), prev_image[i], image[i]);
                end else if (image[i] !== prev_image[i]) begin
                    diff++;
                end
            end
            if (f > 0 && pattern_of(frame_num) != last_pat && diff == 0) begin
                count_errors++;
                $display("Pause: image unchanged although the pattern should have advanced");
            end
            prev_image = image;
            last_pat   = pattern_of(frame_num);
        end
    endtask

    task automatic test_radial_wrap();
        int i;
        // Last checker frame, gradient and radial periods, then the first frame after wrap
        repeat (8) begin
            run_frame("radial_wrap", 1'b0, step_t'($urandom % 8));
        end
        for (i = 0; i < N_PIXELS; i++) begin
            check_rgb($sformatf("radial_wrap zero offset x%0d y%0d", i % H_ACTIVE, i / H_ACTIVE),
                      expected_colour(i % H_ACTIVE, i / H_ACTIVE, PAT_CHECKER, 0), image[i]);
        end
    endtask

    initial begin
        #(TEST_FRAMES * FRAME_CYCLES * 2 * CLK_PERIOD);
        $display("Timeout: the tests did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        void'($urandom(17));
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        test_sync_timing();
        test_blanking();
        test_animation();
        test_pause();
        test_radial_wrap();
        $display("Errors: rgb %0d, sync %0d, count %0d", rgb_errors, sync_errors, count_errors);
        if (rgb_errors + sync_errors + count_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== vga_pattern.f ====
+incdir+verif
logic/vga_pattern_pkg.sv
logic/vga_timing.sv
logic/checkerboard_gen.sv
logic/gradient_gen.sv
logic/radial_arm_gen.sv
logic/pattern_selector.sv
logic/vga_pattern_top.sv
verif/vga_pattern_tb.sv
